//--- hdl/pmpPkg.sv
// PMP package
// Sizes, privilege and address-match codes, the PMP CSR map and the cfg word view
`default_nettype none

package pmpPkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // CSR data width of the core
  localparam int xLen = 32;
  // Physical address width, pmpaddr holds bits 33:2
  localparam int paBits = 34;
  // Entry count is fixed because the CSR map below depends on it
  localparam int pmpEntries = 8;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Privilege modes as the core reports them
  localparam logic [1:0] mMode = 2'd3;
  localparam logic [1:0] sMode = 2'd1;
  localparam logic [1:0] uMode = 2'd0;

  // Address-match modes, found in bits 4:3 of each cfg byte
  localparam logic [1:0] aOff = 2'd0;
  localparam logic [1:0] aTor = 2'd1;
  localparam logic [1:0] aNa4 = 2'd2;
  localparam logic [1:0] aNapot = 2'd3;

  // CSR addresses, each pmpcfg word packs four entries
  localparam logic [11:0] pmpCfgAddr0 = 12'h3A0;
  localparam logic [11:0] pmpCfgAddr1 = 12'h3A1;
  // Entry i sits at pmpAddrBase + i
  localparam logic [11:0] pmpAddrBase = 12'h3B0;

  // One pmpcfg CSR word, seen whole or as four cfg bytes
  // Byte layout is L, two reserved bits, A[1:0], X, W, R from bit 7 down
  typedef union packed {
    logic [xLen-1:0] raw;
    logic [3:0][7:0] cfgBytes;
  } pmpCfgWordT;

endpackage

`default_nettype wire

//--- hdl/priorityOneHot.sv
// Priority picker for the PMP match vector
// Keeps the lowest set bit, so the lowest-numbered entry wins
`timescale 1ns/1ns
`default_nettype none

module priorityOneHot
  import pmpPkg::*;
(
  input  logic [pmpEntries-1:0] a,
  output logic [pmpEntries-1:0] y
);

  // Ripple from bit 0 upward, any set bit below masks the rest
  always_comb begin : rippleChain
    logic seenLower;
    seenLower = 1'b0;
    for (int i = 0; i < pmpEntries; i++) begin
      y[i] = a[i] & ~seenLower;
      seenLower = seenLower | a[i];
    end
  end

endmodule

`default_nettype wire

//--- hdl/pmpAdrDec.sv
// PMP address decoder for one entry
// Matches the physical address in OFF, TOR, NA4 or NAPOT mode and reports gated flags
`timescale 1ns/1ns
`default_nettype none

module pmpAdrDec
  import pmpPkg::*;
(
  input  logic [paBits-1:0] physicalAddress,
  input  logic [7:0]        pmpCfg,
  input  logic [xLen-1:0]   pmpAdr,
  input  logic              paGeAdrIn,
  input  logic              firstMatch,
  output logic              paGeAdrOut,
  output logic              match,
  output logic              active,
  output logic              l,
  output logic              x,
  output logic              w,
  output logic              r
);

  logic [1:0]        adrMode;
  logic              paLtAdr;
  logic              torMatch;
  logic              na4Match;
  logic              napotMatch;
  logic [xLen-1:0]   trailingOnes;
  logic [xLen-1:0]   napotIgnore;

  assign adrMode = pmpCfg[4:3];

  // TOR compares the byte address against pmpaddr scaled back to bytes
  assign paLtAdr = physicalAddress < {pmpAdr, 2'b00};
  // The lower bound of the next entry is this entry's upper bound
  assign paGeAdrOut = ~paLtAdr;
  assign torMatch = paGeAdrIn & paLtAdr;

  // NA4 covers exactly one word
  assign na4Match = physicalAddress[paBits-1:2] == pmpAdr;

  // Isolate the run of trailing ones in the address register
  assign trailingOnes = pmpAdr & ~(pmpAdr + xLen'(1));
  // Those bits and the zero above them are inside the region, the rest must equal
  assign napotIgnore = {trailingOnes[xLen-2:0], 1'b1};
  assign napotMatch = ((physicalAddress[paBits-1:2] ^ pmpAdr) & ~napotIgnore) == '0;

  always_comb begin
    case (adrMode)
      aTor:    match = torMatch;
      aNa4:    match = na4Match;
      aNapot:  match = napotMatch;
      default: match = 1'b0;
    endcase
  end

  assign active = adrMode != aOff;

  // Only the winning entry reports its flags, so the checker can OR them
  assign l = pmpCfg[7] & firstMatch;
  assign x = pmpCfg[2] & firstMatch;
  assign w = pmpCfg[1] & firstMatch;
  assign r = pmpCfg[0] & firstMatch;

endmodule

`default_nettype wire

//--- hdl/pmpChecker.sv
// PMP checker
// Decodes all entries, picks the first match and raises fetch, load and store faults
`timescale 1ns/1ns
`default_nettype none

module pmpChecker
  import pmpPkg::*;
(
  input  logic [paBits-1:0] physicalAddress,
  input  logic [1:0]        privilegeMode,
  input  var logic [7:0]    pmpCfgArray [pmpEntries-1:0],
  input  var logic [xLen-1:0] pmpAddrArray [pmpEntries-1:0],
  input  logic              executeAccessF,
  input  logic              readAccessM,
  input  logic              writeAccessM,
  output logic              instrAccessFaultF,
  output logic              loadAccessFaultM,
  output logic              storeAccessFaultM,
  output logic              squashBusAccess
);

  logic                  enforcePmp;
  logic [pmpEntries-1:0] match;
  logic [pmpEntries-1:0] firstMatch;
  logic [pmpEntries-1:0] active;
  logic [pmpEntries-1:0] paGeAdr;
  logic [pmpEntries-1:0] paGeAdrChain;
  logic [pmpEntries-1:0] l;
  logic [pmpEntries-1:0] x;
  logic [pmpEntries-1:0] w;
  logic [pmpEntries-1:0] r;

  // Entry 0 has zero as its TOR lower bound, so its lower compare is always true
  assign paGeAdrChain = {paGeAdr[pmpEntries-2:0], 1'b1};

  for (genvar i = 0; i < pmpEntries; i++) begin : gEntry
    pmpAdrDec i_pmpAdrDec (
      .physicalAddress (physicalAddress),
      .pmpCfg          (pmpCfgArray[i]),
      .pmpAdr          (pmpAddrArray[i]),
      .paGeAdrIn       (paGeAdrChain[i]),
      .firstMatch      (firstMatch[i]),
      .paGeAdrOut      (paGeAdr[i]),
      .match           (match[i]),
      .active          (active[i]),
      .l               (l[i]),
      .x               (x[i]),
      .w               (w[i]),
      .r               (r[i])
    );
  end

  priorityOneHot i_priorityOneHot (
    .a (match),
    .y (firstMatch)
  );

  // M mode obeys only a locked winner while S and U obey once any entry is on
  always_comb begin
    case (privilegeMode)
      mMode:   enforcePmp = |l;
      default: enforcePmp = |active;
    endcase
  end

  // No match leaves every flag low, so an enforced access then faults
  assign instrAccessFaultF = enforcePmp && executeAccessF && ~|x;
  assign loadAccessFaultM = enforcePmp && readAccessM && ~|r;
  assign storeAccessFaultM = enforcePmp && writeAccessM && ~|w;

  assign squashBusAccess = instrAccessFaultF | loadAccessFaultM | storeAccessFaultM;

endmodule

`default_nettype wire

//--- hdl/pmpCsrFile.sv
// PMP CSR file
// Holds the pmpcfg bytes and pmpaddr registers, applies lock and WARL rules on writes
`timescale 1ns/1ns
`default_nettype none

module pmpCsrFile
  import pmpPkg::*;
(
  input  logic            clk,
  input  logic            arstN,
  input  logic            csrWe,
  input  logic [11:0]     csrAddr,
  input  logic [xLen-1:0] csrWData,
  output logic [xLen-1:0] csrRData,
  output logic [7:0]      pmpCfgArray [pmpEntries-1:0],
  output logic [xLen-1:0] pmpAddrArray [pmpEntries-1:0]
);

  // Stored cfg words, four entries per word
  pmpCfgWordT            cfgReg [pmpEntries/4-1:0];
  // Incoming write data split into byte lanes
  pmpCfgWordT            wrWord;
  logic [7:0]            legalCfg [pmpEntries-1:0];
  logic [pmpEntries-1:0] cfgLocked;
  logic [pmpEntries-1:0] cfgTorMode;
  logic [pmpEntries-1:0] adrLocked;
  logic [pmpEntries-1:0] cfgWe;
  logic [pmpEntries-1:0] adrWe;

  assign wrWord.raw = csrWData;

  //////////////////////////////////////////////////////////////////////
  // Lock state and write legalization
  //////////////////////////////////////////////////////////////////////

  always_comb begin : cfgUnpack
    logic [7:0] wrByte;
    for (int i = 0; i < pmpEntries; i++) begin
      pmpCfgArray[i] = cfgReg[i / 4].cfgBytes[i % 4];
      cfgLocked[i] = cfgReg[i / 4].cfgBytes[i % 4][7];
      cfgTorMode[i] = cfgReg[i / 4].cfgBytes[i % 4][4:3] == aTor;
      // The lane of the write word that lands on this entry
      wrByte = wrWord.cfgBytes[i % 4];
      // Reserved bits forced low, and W survives only together with R
      legalCfg[i] = {wrByte[7], 2'b00, wrByte[4:2], wrByte[1] & wrByte[0], wrByte[0]};
    end
  end

  // A locked TOR entry also freezes the pmpaddr below it, the top entry has no neighbour
  assign adrLocked = cfgLocked |
                     {1'b0, cfgLocked[pmpEntries-1:1] & cfgTorMode[pmpEntries-1:1]};

  // Write strobes per entry, dropped for unmapped addresses and locked targets
  always_comb begin
    for (int i = 0; i < pmpEntries; i++) begin
      // Entries 0..3 live in the first cfg word, 4..7 in the second
      cfgWe[i] = csrWe && !cfgLocked[i] &&
                 (csrAddr == ((i < 4) ? pmpCfgAddr0 : pmpCfgAddr1));
      adrWe[i] = csrWe && !adrLocked[i] && (csrAddr == pmpAddrBase + 12'(i));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cfgReg <= '{default: '0};
      pmpAddrArray <= '{default: '0};
    end else begin
      for (int i = 0; i < pmpEntries; i++) begin
        if (cfgWe[i]) begin
          cfgReg[i / 4].cfgBytes[i % 4] <= legalCfg[i];
        end
        if (adrWe[i]) begin
          pmpAddrArray[i] <= csrWData;
        end
      end
    end
  end

  // Readback is combinational from the address, zero when nothing is mapped there
  always_comb begin
    csrRData = '0;
    if (csrAddr == pmpCfgAddr0) begin
      csrRData = cfgReg[0].raw;
    end else if (csrAddr == pmpCfgAddr1) begin
      csrRData = cfgReg[1].raw;
    end else begin
      for (int i = 0; i < pmpEntries; i++) begin
        if (csrAddr == pmpAddrBase + 12'(i)) begin
          csrRData = pmpAddrArray[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/pmpUnit.sv
// PMP unit top level
// Joins the PMP CSR file to the combinational access checker
`timescale 1ns/1ns
`default_nettype none

module pmpUnit
  import pmpPkg::*;
(
  input  logic              clk,
  input  logic              arstN,
  // CSR port from the core
  input  logic              csrWe,
  input  logic [11:0]       csrAddr,
  input  logic [xLen-1:0]   csrWData,
  output logic [xLen-1:0]   csrRData,
  // Access port from the core
  input  logic [paBits-1:0] physicalAddress,
  input  logic [1:0]        privilegeMode,
  input  logic              executeAccessF,
  input  logic              readAccessM,
  input  logic              writeAccessM,
  // Check results
  output logic              instrAccessFaultF,
  output logic              loadAccessFaultM,
  output logic              storeAccessFaultM,
  output logic              squashBusAccess
);

  // Register state seen by the checker, as of the last clock edge
  logic [7:0]      pmpCfgArray [pmpEntries-1:0];
  logic [xLen-1:0] pmpAddrArray [pmpEntries-1:0];

  pmpCsrFile i_pmpCsrFile (
    .clk          (clk),
    .arstN        (arstN),
    .csrWe        (csrWe),
    .csrAddr      (csrAddr),
    .csrWData     (csrWData),
    .csrRData     (csrRData),
    .pmpCfgArray  (pmpCfgArray),
    .pmpAddrArray (pmpAddrArray)
  );

  pmpChecker i_pmpChecker (
    .physicalAddress   (physicalAddress),
    .privilegeMode     (privilegeMode),
    .pmpCfgArray       (pmpCfgArray),
    .pmpAddrArray      (pmpAddrArray),
    .executeAccessF    (executeAccessF),
    .readAccessM       (readAccessM),
    .writeAccessM      (writeAccessM),
    .instrAccessFaultF (instrAccessFaultF),
    .loadAccessFaultM  (loadAccessFaultM),
    .storeAccessFaultM (storeAccessFaultM),
    .squashBusAccess   (squashBusAccess)
  );

endmodule

`default_nettype wire

//--- tb/pmpModel.svh
// PMP reference model
// Expected match, faults and CSR readback, computed from the shadow registers of pmpTb
`ifndef PMP_MODEL_SVH
`define PMP_MODEL_SVH

// Length of the run of ones at the bottom of a NAPOT address register
function automatic int countTrailingOnes(input logic [31:0] adr);
  int n;
  n = 0;
  while (n < 32 && adr[n]) begin
    n++;
  end
  return n;
endfunction

// Word address bits 33:2 are compared, as the registers hold them
function automatic bit entryMatches(input int idx, input logic [33:0] pa);
  logic [31:0] word;
  logic [31:0] lower;
  int          k;
  word = pa[33:2];
  lower = 32'd0;
  if (idx > 0) begin
    lower = shadowAdr[idx - 1];
  end
  k = countTrailingOnes(shadowAdr[idx]);
  case (shadowCfg[idx][4:3])
    aTor:    return word >= lower && word < shadowAdr[idx];
    aNa4:    return word == shadowAdr[idx];
    // The k trailing ones and the zero above them span the region
    aNapot:  return (64'(word) >> (k + 1)) == (64'(shadowAdr[idx]) >> (k + 1));
    default: return 1'b0;
  endcase
endfunction

// Returns squash, store, load and instruction fault from bit 3 down
function automatic logic [3:0] expectedFaults(input logic [33:0] pa, input logic [1:0] mode,
                                              input logic [2:0] xrw);
  logic [7:0] winner;
  logic [2:0] f;
  bit         found;
  bit         anyActive;
  bit         enforce;
  winner = 8'h00;
  found = 1'b0;
  anyActive = 1'b0;
  for (int i = 0; i < pmpEntries; i++) begin
    if (shadowCfg[i][4:3] != aOff) begin
      anyActive = 1'b1;
    end
    if (!found && entryMatches(i, pa)) begin
      found = 1'b1;
      winner = shadowCfg[i];
    end
  end
  // With no match the winner stays zero and grants nothing
  enforce = (mode == mMode) ? winner[7] : anyActive;
  f[0] = enforce && xrw[2] && !winner[2];
  f[1] = enforce && xrw[1] && !winner[0];
  f[2] = enforce && xrw[0] && !winner[1];
  return {|f, f};
endfunction

function automatic logic [31:0] expectedReadback(input logic [11:0] addr);
  if (addr == pmpCfgAddr0) begin
    return {shadowCfg[3], shadowCfg[2], shadowCfg[1], shadowCfg[0]};
  end
  if (addr == pmpCfgAddr1) begin
    return {shadowCfg[7], shadowCfg[6], shadowCfg[5], shadowCfg[4]};
  end
  for (int i = 0; i < pmpEntries; i++) begin
    if (addr == pmpAddrBase + 12'(i)) begin
      return shadowAdr[i];
    end
  end
  return 32'd0;
endfunction

`endif

//--- tb/pmpTb.sv
// PMP unit testbench
// Drives CSR writes and accesses, checks faults and readback against the reference model
`timescale 1ns/1ns
`default_nettype none

module pmpTb
  import pmpPkg::*;
();

  localparam int clkPeriod = 100;
  localparam int resetWaitLimit = 16;
  localparam int watchdogCycles = 4000;

  logic        clk;
  logic        arstN;
  logic        csrWe;
  logic [11:0] csrAddr;
  logic [31:0] csrWData;
  logic [31:0] csrRData;
  logic [33:0] physicalAddress;
  logic [1:0]  privilegeMode;
  logic        executeAccessF;
  logic        readAccessM;
  logic        writeAccessM;
  logic        instrAccessFaultF;
  logic        loadAccessFaultM;
  logic        storeAccessFaultM;
  logic        squashBusAccess;

  // Shadow copy of the PMP registers, updated at the edge that writes the DUT
  logic [7:0]  shadowCfg [pmpEntries];
  logic [31:0] shadowAdr [pmpEntries];
  logic [3:0]  expFaults;
  logic [31:0] expRData;
  int          faultErrs;
  int          readErrs;
  int          timeoutErrs;
  int          seed;

  `include "pmpModel.svh"

  pmpUnit i_pmpUnit (
    .clk               (clk),
    .arstN             (arstN),
    .csrWe             (csrWe),
    .csrAddr           (csrAddr),
    .csrWData          (csrWData),
    .csrRData          (csrRData),
    .physicalAddress   (physicalAddress),
    .privilegeMode     (privilegeMode),
    .executeAccessF    (executeAccessF),
    .readAccessM       (readAccessM),
    .writeAccessM      (writeAccessM),
    .instrAccessFaultF (instrAccessFaultF),
    .loadAccessFaultM  (loadAccessFaultM),
    .storeAccessFaultM (storeAccessFaultM),
    .squashBusAccess   (squashBusAccess)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(watchdogCycles * clkPeriod);
    $display("Simulation watchdog expired after %0d cycles", watchdogCycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Checks at the rising edge
  //////////////////////////////////////////////////////////////////////

  // The expected squash is the OR of the three expected faults
  faultCheck: assert property (@(posedge clk) disable iff (!arstN)
      {squashBusAccess, storeAccessFaultM, loadAccessFaultM, instrAccessFaultF} == expFaults)
    else begin
      faultErrs++;
      $display("ERR %0t: pa %h mode %0d faults %b%b%b%b, expected %b", $time,
               $sampled(physicalAddress), $sampled(privilegeMode), $sampled(squashBusAccess),
               $sampled(storeAccessFaultM), $sampled(loadAccessFaultM),
               $sampled(instrAccessFaultF), $sampled(expFaults));
    end

  readbackCheck: assert property (@(posedge clk) disable iff (!arstN) csrRData == expRData)
    else begin
      readErrs++;
      $display("ERR %0t: csr %h read %h, expected %h", $time, $sampled(csrAddr),
               $sampled(csrRData), $sampled(expRData));
    end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks that all drive on the falling edge
  //////////////////////////////////////////////////////////////////////

  function automatic void updateExpected();
    expFaults = expectedFaults(physicalAddress, privilegeMode,
                               {executeAccessF, readAccessM, writeAccessM});
    expRData = expectedReadback(csrAddr);
  endfunction

  // Mirrors a CSR write into the shadow registers with the lock and WARL rules
  function automatic void mirrorWrite(input logic [11:0] addr, input logic [31:0] data);
    logic [7:0] b;
    int         base;
    int         idx;
    bit         locked;
    if (addr == pmpCfgAddr0 || addr == pmpCfgAddr1) begin
      base = (addr == pmpCfgAddr0) ? 0 : 4;
      for (int j = 0; j < 4; j++) begin
        b = data[8*j +: 8];
        b[6:5] = 2'b00;
        b[1] = b[1] & b[0];
        if (!shadowCfg[base + j][7]) begin
          shadowCfg[base + j] = b;
        end
      end
    end else if (addr >= pmpAddrBase && addr < pmpAddrBase + 12'(pmpEntries)) begin
      idx = int'(addr - pmpAddrBase);
      locked = shadowCfg[idx][7];
      if (idx < pmpEntries - 1) begin
        locked = locked || (shadowCfg[idx + 1][7] && shadowCfg[idx + 1][4:3] == aTor);
      end
      if (!locked) begin
        shadowAdr[idx] = data;
      end
    end
  endfunction

  task automatic writeCsr(input logic [11:0] addr, input logic [31:0] data);
    @(negedge clk);
    csrWe = 1'b1;
    csrAddr = addr;
    csrWData = data;
    updateExpected();
    @(posedge clk);
    // The DUT takes the write at this edge
    mirrorWrite(addr, data);
  endtask

  task automatic readCsr(input logic [11:0] addr);
    @(negedge clk);
    csrWe = 1'b0;
    csrAddr = addr;
    updateExpected();
    @(posedge clk);
  endtask

  task automatic applyAccess(input logic [33:0] pa, input logic [1:0] mode,
                             input logic [2:0] xrw);
    @(negedge clk);
    csrWe = 1'b0;
    physicalAddress = pa;
    privilegeMode = mode;
    {executeAccessF, readAccessM, writeAccessM} = xrw;
    updateExpected();
    @(posedge clk);
  endtask

  task automatic randomAccess();
    logic [33:0] pa;
    logic [1:0]  mode;
    int          pick;
    pa = {2'b00, $random(seed) & 32'h0000_FFFF};
    pick = int'($unsigned($random(seed)) % 32'd3);
    mode = (pick == 0) ? uMode : ((pick == 1) ? sMode : mMode);
    applyAccess(pa, mode, 3'($random(seed)));
  endtask

  // Each access type alone and all together, in every privilege mode
  task automatic sweepAddress(input logic [33:0] pa);
    logic [1:0] modes [3];
    modes = '{uMode, sMode, mMode};
    for (int m = 0; m < 3; m++) begin
      applyAccess(pa, modes[m], 3'b100);
      applyAccess(pa, modes[m], 3'b010);
      applyAccess(pa, modes[m], 3'b001);
      applyAccess(pa, modes[m], 3'b111);
    end
  endtask

  // Edges of the TOR, NA4 and NAPOT regions, and points outside them
  task automatic sweepRegions();
    sweepAddress(34'h0_0000_0FFC);
    sweepAddress(34'h0_0000_1000);
    sweepAddress(34'h0_0000_1FFC);
    sweepAddress(34'h0_0000_2000);
    sweepAddress(34'h0_0000_3000);
    sweepAddress(34'h0_0000_3004);
    sweepAddress(34'h0_0000_4000);
    sweepAddress(34'h0_0000_4FFC);
    sweepAddress(34'h0_0000_5000);
    sweepAddress(34'h2_0000_3000);
  endtask

  // Mapped CSRs plus one unmapped address on each side
  task automatic readAllCsrs();
    readCsr(pmpCfgAddr0);
    readCsr(pmpCfgAddr1);
    readCsr(12'h3A2);
    for (int i = 0; i <= pmpEntries; i++) begin
      readCsr(pmpAddrBase + 12'(i));
    end
  endtask

  task automatic waitForIdle();
    int cycles;
    cycles = 0;
    while (squashBusAccess !== 1'b0 || csrRData !== 32'h0) begin
      if (cycles == resetWaitLimit) begin
        timeoutErrs++;
        $display("Timed out after %0d cycles waiting for the unit to settle after reset", cycles);
        return;
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    arstN = 1'b0;
    csrWe = 1'b0;
    csrAddr = pmpCfgAddr0;
    csrWData = 32'h0;
    physicalAddress = 34'h0;
    privilegeMode = mMode;
    executeAccessF = 1'b0;
    readAccessM = 1'b0;
    writeAccessM = 1'b0;
    shadowCfg = '{default: '0};
    shadowAdr = '{default: '0};
    expFaults = 4'h0;
    expRData = 32'h0;
    faultErrs = 0;
    readErrs = 0;
    timeoutErrs = 0;
    seed = 53176;
    repeat (8) @(negedge clk);
    arstN = 1'b1;
    waitForIdle();
    // All entries are OFF out of reset
    sweepRegions();
    readAllCsrs();
    // Entry 0 only bounds the TOR of entry 1 with NA4 at 0x3000 and NAPOT over 0x4000..0x4FFF
    writeCsr(pmpAddrBase, 32'h0000_0400);
    writeCsr(pmpAddrBase + 12'd1, 32'h0000_0800);
    writeCsr(pmpAddrBase + 12'd2, 32'h0000_0C00);
    writeCsr(pmpAddrBase + 12'd3, 32'h0000_11FF);
    writeCsr(pmpCfgAddr0, 32'h1C13_0D00);
    sweepRegions();
    // A wide RWX entry 4 under the others, which must still win
    writeCsr(pmpAddrBase + 12'd4, 32'h0000_0FFF);
    writeCsr(pmpCfgAddr1, 32'h0000_001F);
    sweepRegions();
    // Lock the TOR entry 1 and the NA4 entry 2 so that M mode obeys them
    writeCsr(pmpCfgAddr0, 32'h1C93_8D00);
    sweepRegions();
    // Bytes 1 and 2 are locked and pmpaddr0 sits below a locked TOR entry
    // Entry 0 turns into a TOR region from zero up to 0x0FFF with X and R only
    writeCsr(pmpCfgAddr0, 32'h1F1F_1F0D);
    writeCsr(pmpAddrBase, 32'h0000_0123);
    writeCsr(pmpAddrBase + 12'd1, 32'h0000_0456);
    writeCsr(pmpAddrBase + 12'd2, 32'h0000_0789);
    writeCsr(pmpAddrBase + 12'd3, 32'h0000_13FF);
    // Reserved bits set and W without R in every byte
    writeCsr(pmpCfgAddr1, 32'h7E7E_627E);
    readAllCsrs();
    sweepRegions();
    for (int round = 0; round < 30; round++) begin
      writeCsr(pmpCfgAddr1, $random(seed) & 32'h1F1F_1F1F);
      for (int e = 3; e < pmpEntries; e++) begin
        writeCsr(pmpAddrBase + 12'(e), $random(seed) & 32'h0000_1FFF);
      end
      repeat (12) begin
        randomAccess();
      end
    end
    readAllCsrs();
    @(negedge clk);
    csrWe = 1'b0;
    updateExpected();
    // Let the last edges finish their checks
    repeat (2) @(negedge clk);
    $display("Error counts: fault %0d, readback %0d, timeout %0d", faultErrs, readErrs,
             timeoutErrs);
    if (faultErrs + readErrs + timeoutErrs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+tb
hdl/pmpPkg.sv
hdl/priorityOneHot.sv
hdl/pmpAdrDec.sv
hdl/pmpChecker.sv
hdl/pmpCsrFile.sv
hdl/pmpUnit.sv
tb/pmpTb.sv

//--- run.sh
#!/bin/sh
# Build the PMP testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert --top-module pmpTb -f sim.f -o pmpSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/pmpSim > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
  echo "Simulation exited with status $runStatus"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" "$logFile"; then
  echo "Simulation reported failure"
  exit 1
fi
exit 0
